// File: hw/credit_counter.sv
`timescale 1ns/1ns
`default_nettype none

module credit_counter #(
    parameter int unsigned credits = 4
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              issue,
    input  logic                              data_ok,
    input  logic                              discard,
    input  logic                              item_sent,
    input  logic                              credit_return,
    output logic                              may_issue,
    output logic                              credit_ok,
    output logic [fetch_pkg::inflight_w-1:0]  outstanding
);
    localparam int unsigned cw = $clog2(credits + 1);

    // credits held by the fetch side
    logic [cw-1:0] avail;
    // credits promised to requests in flight or items waiting in the queue
    logic [cw-1:0] pending;
    logic          pending_dec;

    // adef items are queued without a reservation
    assign pending_dec = item_sent & (pending != '0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            avail       <= cw'(credits);
            pending     <= '0;
            outstanding <= '0;
        end else begin
            avail       <= avail + cw'(credit_return) - cw'(item_sent);
            outstanding <= outstanding + fetch_pkg::inflight_w'(issue)
                           - fetch_pkg::inflight_w'(data_ok);
            if (discard) begin
                pending <= '0;
            end else begin
                pending <= pending + cw'(issue) - cw'(pending_dec);
            end
        end
    end

    assign may_issue = (avail > pending) &&
                       (outstanding < fetch_pkg::inflight_w'(fetch_pkg::max_inflight));
    assign credit_ok = (avail != '0);

endmodule

`default_nettype wire

// File: hw/fetch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  fetch_pkg::redirect_t  redirect,
    input  logic                  addr_ok,
    input  logic                  data_ok,
    input  logic                  may_issue,
    input  logic                  misaligned,
    output logic                  req,
    output logic                  issue,
    output logic                  discard,
    output logic                  advance,
    output logic                  flush_queue,
    output logic                  push_adef
);
    fetch_pkg::fetch_state_t state;
    fetch_pkg::fetch_state_t state_next;
    logic [fetch_pkg::inflight_w-1:0] cnt;
    logic [fetch_pkg::inflight_w-1:0] cnt_next;
    logic req_want;
    logic accept;

    always_comb begin
        case (state)
            fetch_pkg::issue:     req_want = may_issue & ~misaligned;
            // hold the request until memory takes it
            fetch_pkg::wait_addr: req_want = 1'b1;
            default:              req_want = 1'b0;
        endcase
    end

    // a redirect withdraws any request not yet taken
    assign req    = req_want & ~redirect.valid;
    assign accept = req & addr_ok;

    assign issue       = accept;
    assign advance     = accept;
    assign flush_queue = redirect.valid;
    assign push_adef   = (state == fetch_pkg::issue) & misaligned & ~redirect.valid;

    // responses for the old stream are dropped on arrival
    assign discard = redirect.valid | ((state == fetch_pkg::drain) & data_ok);

    assign cnt_next = cnt + fetch_pkg::inflight_w'(accept) - fetch_pkg::inflight_w'(data_ok);

    always_comb begin
        state_next = state;
        if (redirect.valid) begin
            state_next = (cnt_next != '0) ? fetch_pkg::drain : fetch_pkg::issue;
        end else begin
            case (state)
                fetch_pkg::issue: begin
                    if (misaligned) begin
                        // park after the adef item until the next redirect
                        state_next = fetch_pkg::idle;
                    end else if (req && !addr_ok) begin
                        state_next = fetch_pkg::wait_addr;
                    end
                end
                fetch_pkg::wait_addr: begin
                    if (addr_ok) begin
                        state_next = fetch_pkg::issue;
                    end
                end
                fetch_pkg::drain: begin
                    if (cnt_next == '0) begin
                        state_next = fetch_pkg::issue;
                    end
                end
                default: state_next = state;
            endcase
        end
    end

    // reset lands in drain with nothing to wait for, so req starts a cycle later
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= fetch_pkg::drain;
            cnt   <= '0;
        end else begin
            state <= state_next;
            cnt   <= cnt_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // address and instruction width
    parameter int unsigned addr_w = 32;

    // memory port allows this many accepted but unanswered requests
    parameter int unsigned max_inflight = 2;

    // wide enough to count 0..max_inflight
    parameter int unsigned inflight_w = $clog2(max_inflight + 1);

    // fetch controller states
    typedef enum logic [1:0] {
        idle      = 2'd0,
        issue     = 2'd1,
        wait_addr = 2'd2,
        drain     = 2'd3
    } fetch_state_t;

    // one item handed to decode
    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] inst;
        // address error on fetch
        logic              adef;
    } fetch_item_t;

    // branch or flush request, valid for one cycle
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
    parameter logic [fetch_pkg::addr_w-1:0] reset_pc    = 32'h1c00_0000,
    parameter int unsigned                  credits     = 4,
    parameter int unsigned                  queue_depth = 4
) (
    input  logic                          clk,
    input  logic                          resetn,
    // instruction memory port
    output logic                          req,
    output logic [fetch_pkg::addr_w-1:0]  addr,
    input  logic                          addr_ok,
    input  logic                          data_ok,
    input  logic [fetch_pkg::addr_w-1:0]  rdata,
    // branch or flush
    input  fetch_pkg::redirect_t          redirect,
    // decode side
    output logic                          item_valid,
    output fetch_pkg::fetch_item_t        item,
    input  logic                          credit_return
);
    logic issue;
    logic discard;
    logic advance;
    logic flush_queue;
    logic push_adef;
    logic may_issue;
    logic credit_ok;
    logic misaligned;
    logic item_sent;

    fetch_ctrl i_fetch_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .redirect    (redirect),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .may_issue   (may_issue),
        .misaligned  (misaligned),
        .req         (req),
        .issue       (issue),
        .discard     (discard),
        .advance     (advance),
        .flush_queue (flush_queue),
        .push_adef   (push_adef)
    );

    credit_counter #(
        .credits (credits)
    ) i_credit_counter (
        .clk           (clk),
        .resetn        (resetn),
        .issue         (issue),
        .data_ok       (data_ok),
        .discard       (discard),
        .item_sent     (item_sent),
        .credit_return (credit_return),
        .may_issue     (may_issue),
        .credit_ok     (credit_ok),
        .outstanding   ()
    );

    // the fetch pc is the request address
    pc_gen #(
        .reset_pc (reset_pc)
    ) i_pc_gen (
        .clk        (clk),
        .resetn     (resetn),
        .advance    (advance),
        .redirect   (redirect),
        .pc         (addr),
        .misaligned (misaligned)
    );

    inst_queue #(
        .queue_depth (queue_depth)
    ) i_inst_queue (
        .clk         (clk),
        .resetn      (resetn),
        .push_pc     (issue),
        .pc          (addr),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .discard     (discard),
        .push_adef   (push_adef),
        .flush_queue (flush_queue),
        .credit_ok   (credit_ok),
        .item_valid  (item_valid),
        .item        (item),
        .item_sent   (item_sent)
    );

endmodule

`default_nettype wire

// File: hw/inst_queue.sv
`timescale 1ns/1ns
`default_nettype none

module inst_queue #(
    parameter int unsigned queue_depth = 4
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          push_pc,
    input  logic [fetch_pkg::addr_w-1:0]  pc,
    input  logic                          data_ok,
    input  logic [fetch_pkg::addr_w-1:0]  rdata,
    input  logic                          discard,
    input  logic                          push_adef,
    input  logic                          flush_queue,
    input  logic                          credit_ok,
    output logic                          item_valid,
    output fetch_pkg::fetch_item_t        item,
    output logic                          item_sent
);
    localparam int unsigned pw  = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int unsigned cw  = $clog2(queue_depth + 1);
    localparam int unsigned ipw = $clog2(fetch_pkg::max_inflight);

    // pcs of requests still waiting for data
    logic [fetch_pkg::addr_w-1:0] pc_fifo [fetch_pkg::max_inflight];
    logic [ipw-1:0]               pc_wr;
    logic [ipw-1:0]               pc_rd;

    fetch_pkg::fetch_item_t item_mem [queue_depth];
    fetch_pkg::fetch_item_t new_item;
    logic [pw-1:0]          wr_ptr;
    logic [pw-1:0]          rd_ptr;
    logic [cw-1:0]          count;
    logic                   push;

    always_ff @(posedge clk) begin
        if (push_pc) begin
            pc_fifo[pc_wr] <= pc;
        end
    end

    // every response pops its pc, kept or not
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc_wr <= '0;
            pc_rd <= '0;
        end else begin
            pc_wr <= pc_wr + ipw'(push_pc);
            pc_rd <= pc_rd + ipw'(data_ok);
        end
    end

    always_comb begin
        if (push_adef) begin
            new_item.pc   = pc;
            new_item.inst = '0;
            new_item.adef = 1'b1;
        end else begin
            new_item.pc   = pc_fifo[pc_rd];
            new_item.inst = rdata;
            new_item.adef = 1'b0;
        end
    end

    assign push = (data_ok & ~discard) | push_adef;

    always_ff @(posedge clk) begin
        if (push) begin
            item_mem[wr_ptr] <= new_item;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || flush_queue) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == pw'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (item_sent) begin
                rd_ptr <= (rd_ptr == pw'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cw'(push) - cw'(item_sent);
        end
    end

    // stale head is never shown in the flush cycle
    assign item_valid = (count != '0) & credit_ok & ~flush_queue;
    assign item       = item_mem[rd_ptr];
    assign item_sent  = item_valid;

endmodule

`default_nettype wire

// File: hw/pc_gen.sv
`timescale 1ns/1ns
`default_nettype none

module pc_gen #(
    parameter logic [fetch_pkg::addr_w-1:0] reset_pc = 32'h1c00_0000
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          advance,
    input  fetch_pkg::redirect_t          redirect,
    output logic [fetch_pkg::addr_w-1:0]  pc,
    output logic                          misaligned
);
    logic [fetch_pkg::addr_w-1:0] seq_pc;

    assign seq_pc = pc + fetch_pkg::addr_w'(4);

    // redirect wins over the sequential step
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= reset_pc;
        end else if (redirect.valid) begin
            pc <= redirect.target;
        end else if (advance) begin
            pc <= seq_pc;
        end
    end

    // word fetch only
    assign misaligned = |pc[1:0];

endmodule

`default_nettype wire

// File: sim.f
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/credit_counter.sv
hw/pc_gen.sv
hw/inst_queue.sv
hw/fetch_unit.sv
testbench/fetch_unit_asserts.sv
testbench/tb_fetch_unit.sv

// File: sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_fetch_unit -f sim.f -o sim_tb
status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "SIMULATION FAILED" sim.log; then
    echo "testbench reported failure, see sim.log"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status, see sim.log"
    exit 1
fi

// File: testbench/fetch_unit_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit_asserts #(
    parameter int unsigned credits = 4
) (
    input logic                 clk,
    input logic                 resetn,
    input logic                 req,
    input logic [31:0]          addr,
    input logic                 addr_ok,
    input logic                 data_ok,
    input fetch_pkg::redirect_t redirect,
    input logic                 item_valid,
    input logic                 credit_return
);
    logic [2:0] inflight;
    // credits currently held by the fetch side
    logic [4:0] held;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            inflight <= '0;
            held     <= 5'(credits);
        end else begin
            inflight <= inflight + 3'(req & addr_ok) - 3'(data_ok);
            held     <= held + 5'(credit_return) - 5'(item_valid);
        end
    end

    // only a redirect may withdraw a waiting request
    addr_stable: assert property (@(posedge clk) disable iff (!resetn)
        req && !addr_ok |=> (req || redirect.valid) && $stable(addr))
        else $error("req dropped or addr changed while req waited for addr_ok");

    // a third request must never be offered
    inflight_limit: assert property (@(posedge clk) disable iff (!resetn)
        req |-> inflight < 3'd2)
        else $error("req raised with two requests outstanding");

    credit_held: assert property (@(posedge clk) disable iff (!resetn)
        item_valid |-> held != '0)
        else $error("item_valid high with no credit left");

endmodule

bind fetch_unit fetch_unit_asserts #(
    .credits (credits)
) i_fetch_unit_asserts (
    .clk           (clk),
    .resetn        (resetn),
    .req           (req),
    .addr          (addr),
    .addr_ok       (addr_ok),
    .data_ok       (data_ok),
    .redirect      (redirect),
    .item_valid    (item_valid),
    .credit_return (credit_return)
);

`default_nettype wire

// File: testbench/tb_fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_unit;

    localparam logic [31:0] start_pc  = 32'h1c00_0000;
    localparam int unsigned n_credits = 4;
    localparam logic [31:0] seed      = 32'd59897;
    localparam int          wait_limit = 200;

    // worst case cycles per test, reset included
    localparam int t_seq    = 20 + wait_limit;
    localparam int t_credit = 20 + 2 * wait_limit + 40;
    localparam int t_flush  = 3 * wait_limit + 10;
    localparam int t_adef   = 2 * wait_limit + 50;
    localparam int t_random = 6 * (90 + wait_limit) + wait_limit;
    localparam int budget   = 20 + t_seq + t_credit + t_flush + t_adef + t_random;

    logic                   clk           = 1'b0;
    logic                   resetn        = 1'b0;
    logic                   addr_ok       = 1'b0;
    logic                   data_ok       = 1'b0;
    logic [31:0]            rdata         = '0;
    fetch_pkg::redirect_t   redirect      = '0;
    logic                   credit_return = 1'b0;
    logic                   req;
    logic [31:0]            addr;
    logic                   item_valid;
    fetch_pkg::fetch_item_t item;

    // knobs for the memory and decode models
    logic hold_credits  = 1'b0;
    logic stall_data    = 1'b0;
    logic random_credit = 1'b0;
    int   credit_delay  = 1;

    logic [31:0] mem_rng = seed;
    logic [31:0] crd_rng = ~seed;
    logic [31:0] tst_rng = {seed[15:0], seed[31:16]};
    logic [31:0] mem_addr_q[$];
    int          mem_due_q[$];
    int          credit_q[$];
    int          mem_pending = 0;
    int          cyc = 0;

    logic [31:0] exp_pc     = start_pc;
    logic        parked     = 1'b0;
    int          item_count = 0;
    logic [31:0] last_pc    = '0;
    logic        last_adef  = 1'b0;

    fetch_unit #(
        .reset_pc    (start_pc),
        .credits     (n_credits),
        .queue_depth (4)
    ) i_fetch_unit (
        .clk           (clk),
        .resetn        (resetn),
        .req           (req),
        .addr          (addr),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rdata         (rdata),
        .redirect      (redirect),
        .item_valid    (item_valid),
        .item          (item),
        .credit_return (credit_return)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_now(input string msg);
        $display("error: time %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // in-order memory, returns the inverted address as the instruction
    always @(posedge clk) begin
        if (!resetn) begin
            mem_addr_q.delete();
            mem_due_q.delete();
            addr_ok     <= 1'b0;
            data_ok     <= 1'b0;
            rdata       <= '0;
            mem_pending <= 0;
        end else begin
            if (data_ok) begin
                void'(mem_addr_q.pop_front());
                void'(mem_due_q.pop_front());
            end
            if (req && addr_ok) begin
                mem_rng = xorshift32(mem_rng);
                mem_addr_q.push_back(addr);
                mem_due_q.push_back(cyc + int'(mem_rng[1:0]));
            end
            mem_rng = xorshift32(mem_rng);
            // no third request in flight
            addr_ok <= (mem_addr_q.size() < 2) && (mem_rng[1:0] != 2'b00);
            if (!stall_data && mem_addr_q.size() != 0 && mem_due_q[0] <= cyc) begin
                data_ok <= 1'b1;
                rdata   <= ~mem_addr_q[0];
            end else begin
                data_ok <= 1'b0;
            end
            mem_pending <= mem_addr_q.size();
        end
    end

    // decode side: expected pc stream and credit returns
    always @(posedge clk) begin : decode_model
        int delay;
        if (!resetn) begin
            exp_pc        <= start_pc;
            parked        <= 1'b0;
            credit_return <= 1'b0;
            credit_q.delete();
        end else begin
            if (redirect.valid) begin
                assert (!item_valid) else fail_now("item delivered in the redirect cycle");
                exp_pc <= redirect.target;
                parked <= 1'b0;
            end else if (item_valid) begin
                assert (!parked) else fail_now("item delivered after an address error item");
                if (exp_pc[1:0] != 2'b00) begin
                    assert (item.pc == exp_pc && item.adef && item.inst == '0)
                        else fail_now($sformatf("pc %h inst %h adef %b, expected adef at %h",
                                                item.pc, item.inst, item.adef, exp_pc));
                    parked <= 1'b1;
                end else begin
                    assert (item.pc == exp_pc && !item.adef && item.inst == ~exp_pc)
                        else fail_now($sformatf("pc %h inst %h adef %b, expected pc %h",
                                                item.pc, item.inst, item.adef, exp_pc));
                    exp_pc <= exp_pc + 32'd4;
                end
                item_count <= item_count + 1;
                last_pc    <= item.pc;
                last_adef  <= item.adef;
                delay = credit_delay;
                if (random_credit) begin
                    crd_rng = xorshift32(crd_rng);
                    delay   = int'(crd_rng[2:0]);
                end
                credit_q.push_back(cyc + delay);
            end
            // one credit per pulse
            if (!hold_credits && credit_q.size() != 0 && credit_q[0] <= cyc) begin
                credit_return <= 1'b1;
                void'(credit_q.pop_front());
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        resetn <= 1'b0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
    endtask

    task automatic wait_items(input int n);
        int target;
        int waited;
        target = item_count + n;
        waited = 0;
        while (item_count < target) begin
            @(posedge clk);
            waited++;
            assert (waited <= wait_limit)
                else fail_now($sformatf("%0d items did not arrive in %0d cycles", n, wait_limit));
        end
    endtask

    task automatic send_redirect(input logic [31:0] target);
        @(posedge clk);
        redirect <= {1'b1, target};
        @(posedge clk);
        redirect <= '0;
    endtask

    task automatic check_quiet(input int cycles);
        int start;
        start = item_count;
        repeat (cycles) begin
            @(posedge clk);
            assert (!item_valid && !req) else fail_now("fetch kept running when it should stop");
        end
        assert (item_count == start) else fail_now("items arrived in a quiet window");
    endtask

    task automatic test_sequential();
        credit_delay <= 1;
        wait_items(12);
        assert (last_pc == start_pc + 32'd44)
            else fail_now($sformatf("last pc %h after 12 items", last_pc));
    endtask

    task automatic test_credit_limit();
        hold_credits <= 1'b1;
        apply_reset();
        wait_items(n_credits);
        check_quiet(40);
        hold_credits <= 1'b0;
        wait_items(8);
        assert (last_pc == start_pc + 32'(4 * (n_credits + 7)))
            else fail_now($sformatf("last pc %h after credits resumed", last_pc));
    endtask

    task automatic test_redirect_inflight();
        int waited;
        stall_data <= 1'b1;
        waited = 0;
        while (mem_pending != 2) begin
            @(posedge clk);
            waited++;
            assert (waited <= wait_limit) else fail_now("memory never held two requests");
        end
        send_redirect(32'h0000_8000);
        repeat (3) @(posedge clk);
        stall_data <= 1'b0;
        wait_items(1);
        assert (last_pc == 32'h0000_8000 && !last_adef)
            else fail_now($sformatf("first pc %h after redirect", last_pc));
        wait_items(6);
    endtask

    task automatic test_misaligned();
        send_redirect(32'h0000_9002);
        wait_items(1);
        assert (last_pc == 32'h0000_9002 && last_adef)
            else fail_now($sformatf("pc %h adef %b for misaligned target", last_pc, last_adef));
        check_quiet(40);
        send_redirect(32'h0000_a000);
        wait_items(4);
        assert (last_pc == 32'h0000_a00c && !last_adef)
            else fail_now($sformatf("last pc %h after restart", last_pc));
    endtask

    task automatic test_random_run();
        int          gap;
        logic [31:0] target;
        random_credit <= 1'b1;
        repeat (6) begin
            tst_rng = xorshift32(tst_rng);
            gap     = 20 + int'(tst_rng[5:0]);
            repeat (gap) @(posedge clk);
            tst_rng = xorshift32(tst_rng);
            target  = (tst_rng & 32'h00ff_fffc) | 32'h0010_0000;
            send_redirect(target);
            wait_items(5);
        end
        wait_items(20);
    endtask

    initial begin : watchdog
        repeat (budget) @(posedge clk);
        $display("error: time %0t: run did not finish within %0d cycles", $time, budget);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        apply_reset();
        test_sequential();
        test_credit_limit();
        test_redirect_inflight();
        test_misaligned();
        test_random_run();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
